//--- common/llc_params.svh
// LLC configuration parameters
`ifndef LLC_PARAMS_SVH
`define LLC_PARAMS_SVH

// Cache geometry
`define LLC_SET_ASSO      4
`define LLC_INDEX_LEN     3
`define LLC_NUM_LINES     (1 << `LLC_INDEX_LEN)
`define LLC_NUM_BLOCKS    4
`define LLC_BLOCK_BITS    64

// Address split below the line index
`define LLC_BYTE_OFFSET   3
`define LLC_BLOCK_OFFSET  2

// Bus and register widths
`define LLC_ADDR_W        32
`define LLC_REG_W         32
`define LLC_VERSION       32'h0001_0200

// Register word addresses
`define LLC_REG_CFG_SPM    4'd0
`define LLC_REG_CFG_FLUSH  4'd1
`define LLC_REG_COMMIT     4'd2
`define LLC_REG_FLUSHED    4'd3
`define LLC_REG_BIST_OUT   4'd4
`define LLC_REG_SET_ASSO   4'd5
`define LLC_REG_NUM_LINES  4'd6
`define LLC_REG_NUM_BLOCKS 4'd7
`define LLC_REG_VERSION    4'd8

`endif

//--- common/llc_pkg.sv
// LLC configuration types
`include "llc_params.svh"

package llc_pkg;

  // One bit per cache way
  typedef logic [`LLC_SET_ASSO-1:0] way_mask_t;

  // Cache line index within a way
  typedef logic [`LLC_INDEX_LEN-1:0] line_idx_t;

  // Byte address on the slave port
  typedef logic [`LLC_ADDR_W-1:0] llc_addr_t;

  // Software register data
  typedef logic [`LLC_REG_W-1:0] reg_data_t;

  // Register word address
  typedef logic [3:0] reg_addr_t;

  // Flush controller states
  typedef enum logic [2:0] {
    // Waiting for the tag BIST result
    PreInit,
    // Normal operation, software may reconfigure
    Idle,
    // Slave port isolation requested
    WaitAx,
    // Draining the AW and AR descriptor units
    WaitUnits,
    // Pick the ways to flush and arm the counters
    InitFlush,
    SendFlush,
    WaitFlush,
    // Next way or done
    EndFlush
  } flush_state_e;

endpackage

//--- common/llc_reg_hw_if.sv
// Register file to flush FSM link
interface llc_reg_hw_if;
  import llc_pkg::*;

  // Register contents seen by the hardware
  way_mask_t cfg_spm;
  way_mask_t cfg_flush;
  way_mask_t flushed;
  logic      commit;

  // Hardware updates from the FSM
  logic      spm_we;
  way_mask_t spm_val;
  logic      flushed_we;
  way_mask_t flushed_val;
  logic      flush_clr;
  logic      commit_clr;
  // Software SPM and flush writes blocked
  logic      sw_lock;

  modport regs (
    output cfg_spm, cfg_flush, flushed, commit,
    input  spm_we, spm_val, flushed_we, flushed_val, flush_clr, commit_clr, sw_lock
  );

  modport fsm (
    input  cfg_spm, cfg_flush, flushed, commit,
    output spm_we, spm_val, flushed_we, flushed_val, flush_clr, commit_clr, sw_lock
  );

endinterface

//--- common/llc_flush_cnt_if.sv
// Flush FSM to line counter link
interface llc_flush_cnt_if;
  import llc_pkg::*;

  // Counter control from the FSM
  logic      load;
  logic      clear;
  logic      send_en;
  logic      recv_en;

  // Counter status
  line_idx_t line_idx;
  logic      last_sent;
  logic      all_recv;

  modport cnt (
    input  load, clear, send_en, recv_en,
    output line_idx, last_sent, all_recv
  );

  modport fsm (
    output load, clear, send_en, recv_en,
    input  line_idx, last_sent, all_recv
  );

endinterface

//--- regs/llc_reg_file.sv
// LLC software register block
`include "llc_params.svh"

module llc_reg_file (
  input  logic                clk_i,
  input  logic                rst_i,
  // Software register port
  input  logic                reg_req_i,
  input  logic                reg_we_i,
  input  llc_pkg::reg_addr_t  reg_addr_i,
  input  llc_pkg::reg_data_t  reg_wdata_i,
  output llc_pkg::reg_data_t  reg_rdata_o,
  // Tag macro self-test
  input  llc_pkg::way_mask_t  bist_res_i,
  input  logic                bist_valid_i,
  // Hardware side
  llc_reg_hw_if.regs          hw,
  output llc_pkg::way_mask_t  spm_lock_o,
  output llc_pkg::way_mask_t  flushed_o
);
  import llc_pkg::*;

  way_mask_t cfg_spm_q;
  way_mask_t cfg_flush_q;
  way_mask_t flushed_q;
  way_mask_t bist_q;
  logic      commit_q;
  reg_data_t rdata_d;
  reg_data_t rdata_q;

  // Decoded software writes
  logic      sw_we;
  logic      sw_spm_wr;
  logic      sw_flush_wr;
  logic      sw_commit_wr;

  ////////////////////////////////////////////////////////////
  // Write arbitration
  ////////////////////////////////////////////////////////////

  assign sw_we        = reg_req_i && reg_we_i;
  // SPM and flush masks frozen while a flush is underway
  assign sw_spm_wr    = sw_we && (reg_addr_i == `LLC_REG_CFG_SPM) && !hw.sw_lock;
  assign sw_flush_wr  = sw_we && (reg_addr_i == `LLC_REG_CFG_FLUSH) && !hw.sw_lock;
  assign sw_commit_wr = sw_we && (reg_addr_i == `LLC_REG_COMMIT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_spm_q   <= '0;
      cfg_flush_q <= '0;
      flushed_q   <= '0;
      bist_q      <= '0;
      commit_q    <= 1'b0;
    end else begin
      // Hardware update wins over software in the same cycle
      if (hw.spm_we) begin
        cfg_spm_q <= hw.spm_val;
      end else if (sw_spm_wr) begin
        cfg_spm_q <= reg_wdata_i[`LLC_SET_ASSO-1:0];
      end
      if (hw.flush_clr) begin
        cfg_flush_q <= '0;
      end else if (sw_flush_wr) begin
        cfg_flush_q <= reg_wdata_i[`LLC_SET_ASSO-1:0];
      end
      if (hw.commit_clr) begin
        commit_q <= 1'b0;
      end else if (sw_commit_wr) begin
        commit_q <= reg_wdata_i[0];
      end
      // Flushed status is hardware owned
      if (hw.flushed_we) begin
        flushed_q <= hw.flushed_val;
      end
      if (bist_valid_i) begin
        bist_q <= bist_res_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_addr_i)
      `LLC_REG_CFG_SPM:    rdata_d = reg_data_t'(cfg_spm_q);
      `LLC_REG_CFG_FLUSH:  rdata_d = reg_data_t'(cfg_flush_q);
      `LLC_REG_COMMIT:     rdata_d = reg_data_t'(commit_q);
      `LLC_REG_FLUSHED:    rdata_d = reg_data_t'(flushed_q);
      `LLC_REG_BIST_OUT:   rdata_d = reg_data_t'(bist_q);
      // Geometry constants
      `LLC_REG_SET_ASSO:   rdata_d = reg_data_t'(`LLC_SET_ASSO);
      `LLC_REG_NUM_LINES:  rdata_d = reg_data_t'(`LLC_NUM_LINES);
      `LLC_REG_NUM_BLOCKS: rdata_d = reg_data_t'(`LLC_NUM_BLOCKS);
      `LLC_REG_VERSION:    rdata_d = reg_data_t'(`LLC_VERSION);
      // Unmapped
      default:             rdata_d = '0;
    endcase
  end

  // Read data one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reg_req_i && !reg_we_i) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o = rdata_q;

  // Register contents to the hardware
  assign hw.cfg_spm   = cfg_spm_q;
  assign hw.cfg_flush = cfg_flush_q;
  assign hw.flushed   = flushed_q;
  assign hw.commit    = commit_q;
  assign spm_lock_o   = cfg_spm_q;
  assign flushed_o    = flushed_q;

  // FSM only clears the flush mask while software is locked out
  a_flush_clr_no_sw_wr : assert property (
    @(posedge clk_i) disable iff (rst_i) !(hw.flush_clr && sw_flush_wr)
  ) else $error("flush_clr coincides with an accepted cfg_flush write");

endmodule

//--- flush/llc_flush_counters.sv
// Flush line counters
module llc_flush_counters (
  input  logic             clk_i,
  input  logic             rst_i,
  llc_flush_cnt_if.cnt     cnt
);
  import llc_pkg::*;

  // Index of the descriptor on offer
  line_idx_t sent_q;
  // Completions still expected, minus one
  line_idx_t outst_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sent_q  <= '0;
      outst_q <= '0;
    end else if (cnt.clear) begin
      sent_q  <= '0;
      outst_q <= '0;
    end else if (cnt.load) begin
      // Start of a way
      sent_q  <= '0;
      outst_q <= '1;
    end else begin
      if (cnt.send_en) begin
        sent_q <= sent_q + line_idx_t'(1);
      end
      if (cnt.recv_en) begin
        outst_q <= outst_q - line_idx_t'(1);
      end
    end
  end

  assign cnt.line_idx  = sent_q;
  assign cnt.last_sent = (sent_q == '1);
  assign cnt.all_recv  = (outst_q == '0);

  // FSM never counts a completion past the last line of a way
  a_no_recv_underflow : assert property (
    @(posedge clk_i) disable iff (rst_i) !(cnt.recv_en && cnt.all_recv && !cnt.load)
  ) else $error("completion counted with no flush outstanding");

endmodule

//--- flush/llc_flush_fsm.sv
// LLC flush sequencer
`include "llc_params.svh"

module llc_flush_fsm (
  input  logic                clk_i,
  input  logic                rst_i,
  // Slave port isolation and descriptor unit status
  input  logic                llc_isolated_i,
  input  logic                aw_unit_busy_i,
  input  logic                ar_unit_busy_i,
  // Flush descriptor handshake
  input  logic                desc_ready_i,
  input  logic                flush_desc_recv_i,
  // Tag macro self-test
  input  llc_pkg::way_mask_t  bist_res_i,
  input  logic                bist_valid_i,
  llc_reg_hw_if.fsm           hw,
  output logic                llc_isolate_o,
  output logic                desc_valid_o,
  output llc_pkg::llc_addr_t  desc_addr_o,
  output logic [7:0]          desc_len_o,
  output logic [2:0]          desc_size_o,
  output llc_pkg::way_mask_t  desc_way_o
);
  import llc_pkg::*;

  flush_state_e state_q;
  flush_state_e state_d;
  // Ways still to be flushed
  way_mask_t    target_q;
  way_mask_t    target_d;
  // Lowest pending way, one-hot
  way_mask_t    way_sel;

  llc_flush_cnt_if cnt_if ();

  llc_flush_counters i_counters (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cnt   (cnt_if.cnt)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= PreInit;
      target_q <= '0;
    end else begin
      state_q  <= state_d;
      target_q <= target_d;
    end
  end

  // Isolate lowest set bit
  assign way_sel = target_q & (~target_q + way_mask_t'(1));

  ////////////////////////////////////////////////////////////
  // Next state and register updates
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    target_d       = target_q;
    hw.spm_we      = 1'b0;
    hw.spm_val     = bist_res_i;
    hw.flushed_we  = 1'b0;
    hw.flushed_val = hw.flushed;
    hw.flush_clr   = 1'b0;
    hw.commit_clr  = 1'b0;
    cnt_if.load    = 1'b0;
    cnt_if.clear   = 1'b0;
    cnt_if.send_en = 1'b0;
    cnt_if.recv_en = 1'b0;

    case (state_q)
      PreInit: begin
        // Faulty tag macros start out as SPM so the cache never allocates there
        if (bist_valid_i) begin
          hw.spm_we      = 1'b1;
          hw.flushed_we  = 1'b1;
          hw.flushed_val = bist_res_i;
          state_d        = Idle;
        end
      end
      Idle: begin
        if (hw.commit) begin
          hw.commit_clr = 1'b1;
          state_d       = WaitAx;
        end
      end
      WaitAx: begin
        if (llc_isolated_i) begin
          state_d = WaitUnits;
        end
      end
      WaitUnits: begin
        if (!aw_unit_busy_i && !ar_unit_busy_i) begin
          state_d = InitFlush;
        end
      end
      InitFlush: begin
        if (|hw.cfg_flush) begin
          // Explicit flush request
          target_d = hw.cfg_flush & ~hw.flushed;
        end else begin
          // SPM change, ways leaving SPM lose their flushed mark
          target_d       = hw.cfg_spm & ~hw.flushed;
          hw.flushed_we  = 1'b1;
          hw.flushed_val = hw.cfg_spm & hw.flushed;
        end
        if (target_d == '0) begin
          hw.flush_clr = 1'b1;
          state_d      = Idle;
        end else begin
          cnt_if.load = 1'b1;
          state_d     = SendFlush;
        end
      end
      SendFlush: begin
        if (desc_ready_i) begin
          if (cnt_if.last_sent) begin
            // Final completion may land on the last acceptance
            state_d = (flush_desc_recv_i && cnt_if.all_recv) ? EndFlush : WaitFlush;
          end else begin
            cnt_if.send_en = 1'b1;
          end
        end
        cnt_if.recv_en = flush_desc_recv_i && !cnt_if.all_recv;
      end
      WaitFlush: begin
        if (flush_desc_recv_i) begin
          if (cnt_if.all_recv) begin
            state_d = EndFlush;
          end else begin
            cnt_if.recv_en = 1'b1;
          end
        end
      end
      EndFlush: begin
        cnt_if.clear  = 1'b1;
        hw.flushed_we = 1'b1;
        if (target_q == way_sel) begin
          // Last way done, cache reopens with SPM ways marked flushed
          hw.flushed_val = hw.cfg_spm;
          hw.flush_clr   = 1'b1;
          target_d       = '0;
          state_d        = Idle;
        end else begin
          hw.flushed_val = hw.flushed | way_sel;
          state_d        = InitFlush;
        end
      end
      default: state_d = PreInit;
    endcase
  end

  // Port isolated outside normal operation
  assign hw.sw_lock    = (state_q != Idle);
  assign llc_isolate_o = (state_q != Idle);

  ////////////////////////////////////////////////////////////
  // Flush descriptor
  ////////////////////////////////////////////////////////////

  assign desc_valid_o = (state_q == SendFlush);
  // Line start address within the way
  assign desc_addr_o  = llc_addr_t'(cnt_if.line_idx) << (`LLC_BYTE_OFFSET + `LLC_BLOCK_OFFSET);
  // Whole line as one burst
  assign desc_len_o   = 8'(`LLC_NUM_BLOCKS - 1);
  assign desc_size_o  = 3'($clog2(`LLC_BLOCK_BITS / 8));
  assign desc_way_o   = way_sel;

  a_way_onehot : assert property (
    @(posedge clk_i) disable iff (rst_i) desc_valid_o |-> $onehot(desc_way_o)
  ) else $error("flush descriptor way is not one-hot");

  a_desc_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (desc_valid_o && !desc_ready_i) |=>
      (desc_valid_o && $stable(desc_addr_o) && $stable(desc_way_o))
  ) else $error("flush descriptor changed under back-pressure");

endmodule

//--- verilog/llc_bypass_decode.sv
// LLC AW/AR bypass select
module llc_bypass_decode (
  input  llc_pkg::llc_addr_t aw_addr_i,
  input  llc_pkg::llc_addr_t ar_addr_i,
  // Region bounds, end exclusive
  input  llc_pkg::llc_addr_t cached_start_i,
  input  llc_pkg::llc_addr_t cached_end_i,
  input  llc_pkg::llc_addr_t spm_start_i,
  input  llc_pkg::llc_addr_t spm_end_i,
  input  llc_pkg::way_mask_t flushed_i,
  output logic               aw_bypass_o,
  output logic               ar_bypass_o
);
  import llc_pkg::*;

  // Cached region bypasses once every way is flushed
  logic all_flushed;

  assign all_flushed = &flushed_i;

  // 1 selects the bypass, 0 the cache
  function automatic logic bypass_sel(input llc_addr_t addr);
    logic in_spm;
    logic in_cached;
    in_spm    = (addr >= spm_start_i) && (addr < spm_end_i);
    in_cached = (addr >= cached_start_i) && (addr < cached_end_i);
    if (in_spm) begin
      return 1'b0;
    end else if (in_cached) begin
      return all_flushed;
    end
    // Unmapped goes straight to memory
    return 1'b1;
  endfunction

  // Re-evaluated on region bounds and flushed status as well
  always_comb begin
    aw_bypass_o = bypass_sel(aw_addr_i);
    ar_bypass_o = bypass_sel(ar_addr_i);
  end

endmodule

//--- verilog/llc_cfg_top.sv
// LLC configuration and flush controller
module llc_cfg_top (
  input  logic                clk_i,
  input  logic                rst_i,
  // Software register port
  input  logic                reg_req_i,
  input  logic                reg_we_i,
  input  llc_pkg::reg_addr_t  reg_addr_i,
  input  llc_pkg::reg_data_t  reg_wdata_i,
  output llc_pkg::reg_data_t  reg_rdata_o,
  // Tag macro self-test
  input  llc_pkg::way_mask_t  bist_res_i,
  input  logic                bist_valid_i,
  // Cache side status
  input  logic                llc_isolated_i,
  input  logic                aw_unit_busy_i,
  input  logic                ar_unit_busy_i,
  input  logic                desc_ready_i,
  input  logic                flush_desc_recv_i,
  // Slave port addresses and regions
  input  llc_pkg::llc_addr_t  aw_addr_i,
  input  llc_pkg::llc_addr_t  ar_addr_i,
  input  llc_pkg::llc_addr_t  cached_start_i,
  input  llc_pkg::llc_addr_t  cached_end_i,
  input  llc_pkg::llc_addr_t  spm_start_i,
  input  llc_pkg::llc_addr_t  spm_end_i,
  // Way status to the cache
  output llc_pkg::way_mask_t  spm_lock_o,
  output llc_pkg::way_mask_t  flushed_o,
  output logic                llc_isolate_o,
  // Flush descriptor
  output logic                desc_valid_o,
  output llc_pkg::llc_addr_t  desc_addr_o,
  output logic [7:0]          desc_len_o,
  output logic [2:0]          desc_size_o,
  output llc_pkg::way_mask_t  desc_way_o,
  // Bypass selects
  output logic                aw_bypass_o,
  output logic                ar_bypass_o
);

  llc_reg_hw_if hw_if ();

  llc_reg_file i_reg_file (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .reg_req_i    (reg_req_i),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .bist_res_i   (bist_res_i),
    .bist_valid_i (bist_valid_i),
    .hw           (hw_if.regs),
    .spm_lock_o   (spm_lock_o),
    .flushed_o    (flushed_o)
  );

  llc_flush_fsm i_flush_fsm (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .llc_isolated_i    (llc_isolated_i),
    .aw_unit_busy_i    (aw_unit_busy_i),
    .ar_unit_busy_i    (ar_unit_busy_i),
    .desc_ready_i      (desc_ready_i),
    .flush_desc_recv_i (flush_desc_recv_i),
    .bist_res_i        (bist_res_i),
    .bist_valid_i      (bist_valid_i),
    .hw                (hw_if.fsm),
    .llc_isolate_o     (llc_isolate_o),
    .desc_valid_o      (desc_valid_o),
    .desc_addr_o       (desc_addr_o),
    .desc_len_o        (desc_len_o),
    .desc_size_o       (desc_size_o),
    .desc_way_o        (desc_way_o)
  );

  // Bypass follows the registered flushed status
  llc_bypass_decode i_bypass_decode (
    .aw_addr_i      (aw_addr_i),
    .ar_addr_i      (ar_addr_i),
    .cached_start_i (cached_start_i),
    .cached_end_i   (cached_end_i),
    .spm_start_i    (spm_start_i),
    .spm_end_i      (spm_end_i),
    .flushed_i      (flushed_o),
    .aw_bypass_o    (aw_bypass_o),
    .ar_bypass_o    (ar_bypass_o)
  );

endmodule

//--- dv/llc_cfg_tb.sv
// LLC configuration controller testbench
`include "llc_params.svh"

module llc_cfg_tb;
  import llc_pkg::*;

  // Watchdog cycles allowed per pattern line
  localparam int LINE_BUDGET = 400;
  // Address map, end exclusive
  localparam llc_addr_t SPM_START    = 32'h1000_0000;
  localparam llc_addr_t SPM_END      = 32'h1001_0000;
  localparam llc_addr_t CACHED_START = 32'h8000_0000;
  localparam llc_addr_t CACHED_END   = 32'h9000_0000;

  logic       clk_i;
  logic       rst_i;
  logic       reg_req_i;
  logic       reg_we_i;
  reg_addr_t  reg_addr_i;
  reg_data_t  reg_wdata_i;
  reg_data_t  reg_rdata_o;
  way_mask_t  bist_res_i;
  logic       bist_valid_i;
  logic       llc_isolated_i;
  logic       aw_unit_busy_i;
  logic       ar_unit_busy_i;
  logic       desc_ready_i;
  logic       flush_desc_recv_i;
  llc_addr_t  aw_addr_i;
  llc_addr_t  ar_addr_i;
  llc_addr_t  cached_start_i;
  llc_addr_t  cached_end_i;
  llc_addr_t  spm_start_i;
  llc_addr_t  spm_end_i;
  way_mask_t  spm_lock_o;
  way_mask_t  flushed_o;
  logic       llc_isolate_o;
  logic       desc_valid_o;
  llc_addr_t  desc_addr_o;
  logic [7:0] desc_len_o;
  logic [2:0] desc_size_o;
  way_mask_t  desc_way_o;
  logic       aw_bypass_o;
  logic       ar_bypass_o;

  // Reference copies of the writable registers
  way_mask_t   model_spm;
  way_mask_t   model_flush;
  way_mask_t   model_flushed;
  way_mask_t   model_bist;
  // Accepted descriptors packed as way, len, size, addr
  logic [46:0] desc_q[$];
  string       lines[$];
  int          line_cnt = 0;
  int          err_cnt = 0;
  logic [7:0]  lfsr_q;

  llc_cfg_top llc_cfg_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // x^8 + x^6 + x^5 + x^4 + 1, one step per bit
  function automatic logic next_rand_bit();
    logic fb;
    fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return lfsr_q[0];
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
    err_cnt++;
  endtask

  // Way status outputs follow the register model
  task automatic check_status(input string name);
    if (spm_lock_o !== model_spm) begin
      report_mismatch({name, " spm_lock"}, 64'(model_spm), 64'(spm_lock_o));
    end
    if (flushed_o !== model_flushed) begin
      report_mismatch({name, " flushed"}, 64'(model_flushed), 64'(flushed_o));
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_req_i   = 1'b1;
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk_i);
    #2;
    reg_req_i = 1'b0;
    reg_we_i  = 1'b0;
  endtask

  // Data is registered on the edge after the request
  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    reg_req_i  = 1'b1;
    reg_we_i   = 1'b0;
    reg_addr_i = addr;
    @(posedge clk_i);
    #2;
    reg_req_i = 1'b0;
    data      = reg_rdata_o;
  endtask

  // SPM never bypasses, cached only once every way is flushed
  function automatic logic expected_bypass(input llc_addr_t addr);
    if (addr >= SPM_START && addr < SPM_END) begin
      return 1'b0;
    end else if (addr >= CACHED_START && addr < CACHED_END) begin
      return &model_flushed;
    end
    return 1'b1;
  endfunction

  task automatic bist_load(input string name, input way_mask_t mask);
    if (llc_isolate_o !== 1'b1) report_mismatch({name, " isolate"}, 64'(1), 64'(llc_isolate_o));
    if (desc_valid_o !== 1'b0) report_mismatch({name, " valid"}, 64'(0), 64'(desc_valid_o));
    bist_res_i   = mask;
    bist_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    bist_valid_i = 1'b0;
    if (llc_isolate_o !== 1'b0) report_mismatch({name, " idle"}, 64'(0), 64'(llc_isolate_o));
    model_spm     = mask;
    model_flushed = mask;
    model_bist    = mask;
    model_flush   = '0;
    check_status(name);
  endtask

  task automatic run_flush(input string name, input logic lock_wr, input reg_addr_t lock_addr,
                           input reg_data_t lock_data, input int exp_cnt);
    way_mask_t   tgt;
    logic [46:0] exp_q[$];
    // Explicit request wins, otherwise ways newly taken as SPM
    tgt = (model_flush != '0) ? (model_flush & ~model_flushed) : (model_spm & ~model_flushed);
    for (int w = 0; w < `LLC_SET_ASSO; w++) begin
      for (int i = 0; i < `LLC_NUM_LINES; i++) begin
        if (tgt[w]) begin
          // Lines are a whole number of 8-byte blocks apart
          exp_q.push_back({way_mask_t'(1 << w), 8'(`LLC_NUM_BLOCKS - 1),
                           3'(`LLC_BYTE_OFFSET),
                           llc_addr_t'(i * `LLC_NUM_BLOCKS * (`LLC_BLOCK_BITS / 8))});
        end
      end
    end
    if (exp_q.size() != exp_cnt) begin
      report_mismatch({name, " planned"}, 64'(exp_cnt), 64'(exp_q.size()));
    end
    desc_q.delete();
    reg_write(`LLC_REG_COMMIT, 32'd1);
    if (llc_isolate_o !== 1'b0) report_mismatch({name, " early"}, 64'(0), 64'(llc_isolate_o));
    @(posedge clk_i);
    #2;
    if (llc_isolate_o !== 1'b1) report_mismatch({name, " isolate"}, 64'(1), 64'(llc_isolate_o));
    if (lock_wr) begin
      while (desc_valid_o !== 1'b1) begin
        @(posedge clk_i);
        #2;
      end
      reg_write(lock_addr, lock_data);
    end
    // Flush is over once the port reopens
    while (llc_isolate_o !== 1'b0) begin
      @(posedge clk_i);
      #2;
    end
    if (desc_q.size() != exp_q.size()) begin
      report_mismatch({name, " count"}, 64'(exp_q.size()), 64'(desc_q.size()));
    end
    foreach (exp_q[i]) begin
      if (i < desc_q.size() && desc_q[i] !== exp_q[i]) begin
        report_mismatch($sformatf("%s desc %0d", name, i), 64'(exp_q[i]), 64'(desc_q[i]));
      end
    end
    if (desc_valid_o !== 1'b0) report_mismatch({name, " valid"}, 64'(0), 64'(desc_valid_o));
    // Empty explicit request leaves flushed alone
    if (model_flush == '0 || tgt != '0) begin
      model_flushed = model_spm;
    end
    model_flush = '0;
    check_status(name);
  endtask

  task automatic run_command(input string name, input string cmd, input reg_data_t a1,
                             input reg_data_t a2, input reg_data_t ex);
    reg_data_t rdata;
    reg_data_t mref;
    if (cmd == "bist") begin
      bist_load(name, way_mask_t'(a1));
    end else if (cmd == "write") begin
      reg_write(reg_addr_t'(a1), a2);
      if (a1 == 0) model_spm = way_mask_t'(a2);
      if (a1 == 1) model_flush = way_mask_t'(a2);
      check_status(name);
    end else if (cmd == "read") begin
      reg_read(reg_addr_t'(a1), rdata);
      if (rdata !== ex) report_mismatch(name, 64'(ex), 64'(rdata));
      case (a1)
        0: mref = reg_data_t'(model_spm);
        1: mref = reg_data_t'(model_flush);
        // Commit self-clears once the flush starts
        2: mref = '0;
        3: mref = reg_data_t'(model_flushed);
        4: mref = reg_data_t'(model_bist);
        5: mref = reg_data_t'(`LLC_SET_ASSO);
        6: mref = reg_data_t'(1 << `LLC_INDEX_LEN);
        7: mref = reg_data_t'(`LLC_NUM_BLOCKS);
        8: mref = reg_data_t'(`LLC_VERSION);
        default: mref = '0;
      endcase
      if (rdata !== mref) report_mismatch({name, " model"}, 64'(mref), 64'(rdata));
    end else if (cmd == "commit") begin
      run_flush(name, 1'b0, '0, '0, int'(ex));
    end else if (cmd == "lockwr") begin
      run_flush(name, 1'b1, reg_addr_t'(a1), a2, int'(ex));
    end else if (cmd == "bypass") begin
      aw_addr_i = a1;
      ar_addr_i = a1;
      @(negedge clk_i);
      if (aw_bypass_o !== ex[0]) report_mismatch({name, " aw"}, 64'(ex[0]), 64'(aw_bypass_o));
      if (ar_bypass_o !== ex[0]) report_mismatch({name, " ar"}, 64'(ex[0]), 64'(ar_bypass_o));
      if (aw_bypass_o !== expected_bypass(a1)) begin
        report_mismatch({name, " model"}, 64'(expected_bypass(a1)), 64'(aw_bypass_o));
      end
      @(posedge clk_i);
      #2;
    end else begin
      $display("Unknown pattern command %s", name);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cache side responder
  ////////////////////////////////////////////////////////////

  initial begin : cache_side
    int   iso_cnt;
    int   pending;
    logic rb;
    iso_cnt           = 0;
    pending           = 0;
    lfsr_q            = 8'd27;
    llc_isolated_i    = 1'b0;
    aw_unit_busy_i    = 1'b0;
    ar_unit_busy_i    = 1'b0;
    desc_ready_i      = 1'b0;
    flush_desc_recv_i = 1'b0;
    forever begin
      // Mid-cycle sample of the handshake taken at the next edge
      @(negedge clk_i);
      if (desc_valid_o && desc_ready_i) begin
        desc_q.push_back({desc_way_o, desc_len_o, desc_size_o, desc_addr_o});
        pending++;
      end
      iso_cnt = llc_isolate_o ? iso_cnt + 1 : 0;
      @(posedge clk_i);
      #2;
      llc_isolated_i = (iso_cnt >= 3);
      desc_ready_i   = next_rand_bit();
      rb             = next_rand_bit();
      // At most one completion per cycle
      if (pending > 0 && rb) begin
        flush_desc_recv_i = 1'b1;
        pending--;
      end else begin
        flush_desc_recv_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (line_cnt > 0);
    repeat (16 + line_cnt * LINE_BUDGET) @(posedge clk_i);
    $display("Watchdog expired before the pattern file was finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main_seq
    int        fd;
    int        n;
    string     ln;
    string     cmd;
    reg_data_t a1;
    reg_data_t a2;
    reg_data_t ex;
    rst_i          = 1'b1;
    reg_req_i      = 1'b0;
    reg_we_i       = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    bist_res_i     = '0;
    bist_valid_i   = 1'b0;
    aw_addr_i      = '0;
    ar_addr_i      = '0;
    cached_start_i = CACHED_START;
    cached_end_i   = CACHED_END;
    spm_start_i    = SPM_START;
    spm_end_i      = SPM_END;
    model_spm      = '0;
    model_flush    = '0;
    model_flushed  = '0;
    model_bist     = '0;
    fd = $fopen("dv/llc_cfg_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file dv/llc_cfg_patterns.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      while ($fgets(ln, fd) > 0) begin
        lines.push_back(ln);
      end
      $fclose(fd);
      line_cnt = lines.size();
      repeat (16) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      foreach (lines[i]) begin
        ln = lines[i];
        // Skip blank and comment lines
        if (ln.len() > 2 && ln[0] != "#") begin
          n = $sscanf(ln, "%s %h %h %h", cmd, a1, a2, ex);
          if (n != 4) begin
            $display("Pattern line %0d could not be parsed", i + 1);
            err_cnt++;
          end else begin
            run_command($sformatf("%s@%0d", cmd, i + 1), cmd, a1, a2, ex);
          end
        end
      end
      $display("Run complete with %0d errors", err_cnt);
      if (err_cnt == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

//--- dv/llc_cfg_patterns.txt
# cmd arg1 arg2 expect, all hex; bist: arg1 mask; write/read: arg1 reg, arg2 data, expect rdata
# commit: expect descriptors; lockwr: arg1 reg, arg2 data, expect descriptors; bypass: arg1 addr
bist 2 0 0
read 0 0 2
read 3 0 2
read 4 0 2
read 5 0 4
read 6 0 8
read 7 0 4
read 8 0 10200
read f 0 0
write 5 ff 0
read 5 0 4
bypass 10000040 0 0
bypass 80000100 0 0
bypass 20000000 0 1
write 1 b 0
read 1 0 b
commit 0 0 10
read 3 0 2
read 1 0 0
write 0 6 0
commit 0 0 8
read 3 0 6
write 1 1 0
lockwr 0 f 8
read 0 0 6
read 3 0 6
commit 0 0 0
read 2 0 0
read 3 0 6
write 0 f 0
commit 0 0 10
read 3 0 f
bypass 80000100 0 1
bypass 8fffffff 0 1
bypass 1000ffff 0 0
bypass 90000000 0 1

//--- sim.f
+incdir+common
common/llc_pkg.sv
common/llc_reg_hw_if.sv
common/llc_flush_cnt_if.sv
regs/llc_reg_file.sv
flush/llc_flush_counters.sv
flush/llc_flush_fsm.sv
verilog/llc_bypass_decode.sv
verilog/llc_cfg_top.sv
dv/llc_cfg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the LLC configuration testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=llc_cfg_sim

rm -f "$LOG"
verilator --binary --timing --assert -f sim.f --top-module llc_cfg_tb -o "$BIN" \
  && ./obj_dir/"$BIN" > "$LOG" 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "^TEST PASS$" "$LOG" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see $LOG"; exit 1; }
